//--- alu_execute.sv
`timescale 1ns/1ps

module alu_execute (
    input  tenyr_pkg::opcode_t           op,
    input  logic [tenyr_pkg::word_w-1:0] a,
    input  logic [tenyr_pkg::word_w-1:0] b,
    input  logic [tenyr_pkg::word_w-1:0] imm,
    output logic [tenyr_pkg::word_w-1:0] result,
    output logic [tenyr_pkg::addr_w-1:0] mem_addr,
    output logic                         take_branch
);

    logic [tenyr_pkg::word_w-1:0] b_imm;
    logic [tenyr_pkg::word_w-1:0] eff_addr;

    assign b_imm = b + imm; // Second operand of every instruction

    always_comb begin
        case (op)
            tenyr_pkg::ADD: result = a + b_imm;
            tenyr_pkg::SUB: result = a - b_imm;
            tenyr_pkg::AND: result = a & b_imm;
            tenyr_pkg::OR:  result = a | b_imm;
            tenyr_pkg::XOR: result = a ^ b_imm;
            tenyr_pkg::SHL: result = a << b_imm[4:0];
            tenyr_pkg::LT: begin
                result = '0;
                result[0] = $signed(a) < $signed(b_imm);
            end
            default:        result = '0;
        endcase
    end

    // Loads and stores address memory at A plus I
    assign eff_addr = a + imm;
    assign mem_addr = eff_addr[tenyr_pkg::addr_w-1:0];

    assign take_branch = (op == tenyr_pkg::BNZ) && (a != '0);

endmodule

//--- block_mem.sv
`timescale 1ns/1ps

module block_mem (
    input  logic                         clk,
    input  logic [tenyr_pkg::addr_w-1:0] i_addr,
    output logic [tenyr_pkg::word_w-1:0] i_data,
    input  logic [tenyr_pkg::addr_w-1:0] ram_addr,
    input  logic                         ram_we,
    input  logic [tenyr_pkg::word_w-1:0] ram_wdata,
    output logic [tenyr_pkg::word_w-1:0] ram_rdata
);

    localparam int idx_w = $clog2(tenyr_pkg::ram_words);

    logic [tenyr_pkg::word_w-1:0] mem [tenyr_pkg::ram_words];

    initial begin
        $readmemh("program.hex", mem);
    end

    // Instruction port is read only
    always_ff @(posedge clk) begin
        i_data <= mem[i_addr[idx_w-1:0]];
    end

    // Data port returns the old word on a write
    always_ff @(posedge clk) begin
        if (ram_we) begin
            mem[ram_addr[idx_w-1:0]] <= ram_wdata;
        end
        ram_rdata <= mem[ram_addr[idx_w-1:0]];
    end

endmodule

//--- core.sv
`timescale 1ns/1ps

module core (
    input  logic                         clk,
    input  logic                         arst_n,
    output logic [tenyr_pkg::addr_w-1:0] i_addr,
    input  logic [tenyr_pkg::word_w-1:0] i_data,
    output logic [tenyr_pkg::addr_w-1:0] d_addr,
    output logic [tenyr_pkg::word_w-1:0] d_wdata,
    output logic                         d_we,
    input  logic [tenyr_pkg::word_w-1:0] d_rdata,
    output logic                         halt
);

    tenyr_pkg::core_state_t       state;
    logic [tenyr_pkg::addr_w-1:0] pc;

    tenyr_pkg::opcode_t           op;
    logic [3:0]                   rd;
    logic [3:0]                   ra;
    logic [3:0]                   rb;
    logic [tenyr_pkg::word_w-1:0] imm;
    logic                         writes_reg;
    logic [tenyr_pkg::word_w-1:0] a;
    logic [tenyr_pkg::word_w-1:0] b;
    logic [tenyr_pkg::word_w-1:0] result;
    logic                         take_branch;
    logic                         wr_en;
    logic [tenyr_pkg::word_w-1:0] wr_data;

    insn_decode insn_decode_i (
        .insn(i_data), .op(op), .rd(rd), .ra(ra), .rb(rb), .imm(imm),
        .writes_reg(writes_reg)
    );

    alu_execute alu_execute_i (
        .op(op), .a(a), .b(b), .imm(imm), .result(result),
        .mem_addr(d_addr), .take_branch(take_branch)
    );

    result_commit result_commit_i (
        .clk(clk), .arst_n(arst_n), .ra(ra), .rb(rb), .a(a), .b(b),
        .wr_en(wr_en), .wr_idx(rd), .wr_data(wr_data)
    );

    assign i_addr  = pc; // Held through EXEC and LOAD_WAIT so i_data stays valid
    assign d_wdata = b;
    assign d_we    = (state == tenyr_pkg::EXEC) && (op == tenyr_pkg::STORE);

    // ALU results commit in EXEC, load data one cycle later
    assign wr_en = ((state == tenyr_pkg::EXEC) && writes_reg && (op != tenyr_pkg::LOAD))
                || (state == tenyr_pkg::LOAD_WAIT);
    assign wr_data = (state == tenyr_pkg::LOAD_WAIT) ? d_rdata : result;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc    <= '0;
            state <= tenyr_pkg::FETCH;
            halt  <= 1'b0;
        end else begin
            case (state)
                tenyr_pkg::FETCH: begin
                    if (!halt) begin // A halted core parks here
                        state <= tenyr_pkg::EXEC;
                    end
                end
                tenyr_pkg::EXEC: begin
                    case (op)
                        tenyr_pkg::LOAD: state <= tenyr_pkg::LOAD_WAIT;
                        tenyr_pkg::HALT: begin
                            halt  <= 1'b1;
                            state <= tenyr_pkg::FETCH;
                        end
                        default: begin
                            pc    <= take_branch ? imm[tenyr_pkg::addr_w-1:0] : pc + 1'b1;
                            state <= tenyr_pkg::FETCH;
                        end
                    endcase
                end
                tenyr_pkg::LOAD_WAIT: begin
                    pc    <= pc + 1'b1;
                    state <= tenyr_pkg::FETCH;
                end
                default: state <= tenyr_pkg::FETCH;
            endcase
        end
    end

endmodule

//--- data_bus_map.sv
`timescale 1ns/1ps

module data_bus_map (
    input  logic                         clk,
    input  logic                         arst_n,
    input  logic [tenyr_pkg::addr_w-1:0] d_addr,
    input  logic [tenyr_pkg::word_w-1:0] d_wdata,
    input  logic                         d_we,
    output logic [tenyr_pkg::word_w-1:0] d_rdata,
    output logic                         ram_we,
    input  logic [tenyr_pkg::word_w-1:0] ram_rdata,
    output logic [15:0]                  display,
    output logic [7:0]                   led
);

    logic                         in_ram;
    logic                         sel_ram;
    logic [tenyr_pkg::word_w-1:0] reg_rdata;

    assign in_ram = d_addr < tenyr_pkg::ram_words;
    assign ram_we = d_we && in_ram;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            display <= '0;
            led     <= '0;
            sel_ram <= 1'b1;
        end else begin
            sel_ram <= in_ram; // Read select lines up with the RAM latency
            if (d_we && (d_addr == tenyr_pkg::display_addr)) begin
                display <= d_wdata[15:0];
            end
            if (d_we && (d_addr == tenyr_pkg::led_addr)) begin
                led <= d_wdata[7:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (d_addr == tenyr_pkg::display_addr) begin
            reg_rdata <= {{(tenyr_pkg::word_w-16){1'b0}}, display};
        end else if (d_addr == tenyr_pkg::led_addr) begin
            reg_rdata <= {{(tenyr_pkg::word_w-8){1'b0}}, led};
        end else begin
            reg_rdata <= '0; // Unmapped addresses read zero
        end
    end

    assign d_rdata = sel_ram ? ram_rdata : reg_rdata;

endmodule

//--- insn_decode.sv
`timescale 1ns/1ps

module insn_decode (
    input  logic [tenyr_pkg::word_w-1:0] insn,
    output tenyr_pkg::opcode_t           op,
    output logic [3:0]                   rd,
    output logic [3:0]                   ra,
    output logic [3:0]                   rb,
    output logic [tenyr_pkg::word_w-1:0] imm,
    output logic                         writes_reg
);

    assign rd = insn[27:24];
    assign ra = insn[23:20];
    assign rb = insn[19:16];

    // Immediate is signed and widened to a full word
    assign imm = {{(tenyr_pkg::word_w-16){insn[15]}}, insn[15:0]};

    always_comb begin
        case (insn[31:28])
            tenyr_pkg::ADD,
            tenyr_pkg::SUB,
            tenyr_pkg::AND,
            tenyr_pkg::OR,
            tenyr_pkg::XOR,
            tenyr_pkg::SHL,
            tenyr_pkg::LT,
            tenyr_pkg::LOAD,
            tenyr_pkg::STORE,
            tenyr_pkg::BNZ,
            tenyr_pkg::HALT: op = tenyr_pkg::opcode_t'(insn[31:28]);
            default:         op = tenyr_pkg::NOP;
        endcase
    end

    always_comb begin
        writes_reg = op inside {tenyr_pkg::ADD, tenyr_pkg::SUB, tenyr_pkg::AND,
                                tenyr_pkg::OR, tenyr_pkg::XOR, tenyr_pkg::SHL,
                                tenyr_pkg::LT, tenyr_pkg::LOAD};
    end

endmodule

//--- program.hex
// One instruction per line from word 0: opcode, rd, ra, rb nibbles, then the signed immediate
0100000A
02000000
02210000
11100001
90100002
80020384
73000384
80030400
0400005A
4440000F
05000001
55500007
34450000
244000FF
80040401
06000003
67600005
80070385
08370000
80080400
A0000000

//--- result_commit.sv
`timescale 1ns/1ps

module result_commit (
    input  logic                         clk,
    input  logic                         arst_n,
    input  logic [3:0]                   ra,
    input  logic [3:0]                   rb,
    output logic [tenyr_pkg::word_w-1:0] a,
    output logic [tenyr_pkg::word_w-1:0] b,
    input  logic                         wr_en,
    input  logic [3:0]                   wr_idx,
    input  logic [tenyr_pkg::word_w-1:0] wr_data
);

    logic [tenyr_pkg::word_w-1:0] regs [tenyr_pkg::reg_count];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < tenyr_pkg::reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (wr_idx != 4'd0)) begin // Register 0 ignores writes
            regs[wr_idx] <= wr_data;
        end
    end

    always_comb begin
        if (ra == 4'd0) begin
            a = '0;
        end else begin
            a = regs[ra];
        end
    end

    always_comb begin
        if (rb == 4'd0) begin
            b = '0;
        end else begin
            b = regs[rb];
        end
    end

endmodule

//--- sources.f
tenyr_pkg.sv
insn_decode.sv
alu_execute.sv
result_commit.sv
core.sv
block_mem.sv
data_bus_map.sv
tenyr_soc.sv
tb_clock.sv
tb_tenyr_assertions.sv
tb_tenyr.sv

//--- tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
    input  logic restart,
    output logic clk,
    output logic arst_n
);

    localparam int half_period = 10;

    initial begin
        clk = 1'b0;
        forever begin
            #(half_period) clk = ~clk;
        end
    end

    initial begin
        arst_n = 1'b0;
        forever begin
            repeat (4) @(posedge clk); // Reset spans four rising edges
            #1 arst_n = 1'b1;
            @(posedge restart);
            @(posedge clk);
            #1 arst_n = 1'b0;
        end
    end

endmodule

//--- tb_tenyr.sv
`timescale 1ns/1ps

module tb_tenyr;

    localparam int clk_period = 20;
    localparam int run_cycles = 400;
    localparam int runs = 2;

    logic        clk;
    logic        arst_n;
    logic        restart;
    logic        halt;
    logic [15:0] display;
    logic [7:0]  led;

    int          errors = 0;
    logic [15:0] display_seq [$];
    logic [15:0] last_display;

    tb_clock tb_clock_i (.restart(restart), .clk(clk), .arst_n(arst_n));

    tenyr_soc tenyr_soc_i (
        .clk(clk), .arst_n(arst_n), .halt(halt), .display(display), .led(led)
    );

    function automatic int sum_to(input int n);
        int s;
        s = 0;
        for (int k = 1; k <= n; k++) begin
            s += k;
        end
        return s;
    endfunction

    task automatic check_value(input string name, input int actual, input int expected);
        assert (actual == expected) else begin
            errors++;
            $display("FAIL %0t %s expected 0x%0h actual 0x%0h", $time, name, expected, actual);
        end
    endtask

    always @(negedge clk) begin
        if (!arst_n) begin
            display_seq.delete();
            last_display = 16'd0;
        end else if (display != last_display) begin
            display_seq.push_back(display); // Every value the display takes in one run
            last_display = display;
        end
    end

    initial begin
        int         sum;
        int         lt_bit;
        int         assert_errors;
        logic [7:0] led_expect;
        restart = 1'b0;
        sum = sum_to(10);
        lt_bit = (3 < 5) ? 1 : 0;
        led_expect = ((8'h5A ^ 8'h0F) | (8'h01 << 7)) & 8'hFF;
        for (int run = 0; run < runs; run++) begin
            wait (arst_n === 1'b1);
            while (halt !== 1'b1) begin
                @(negedge clk);
            end
            repeat (4) @(negedge clk);
            check_value("display_seq.size", display_seq.size(), 2);
            if (display_seq.size() == 2) begin
                check_value("display_seq[0]", display_seq[0], sum);
                check_value("display_seq[1]", display_seq[1], sum + lt_bit);
            end
            check_value("led", led, led_expect);
            check_value("display", display, sum + lt_bit);
            if (run < runs - 1) begin
                @(posedge clk);
                #1 restart = 1'b1;
                wait (arst_n === 1'b0);
                restart = 1'b0;
            end
        end
        assert_errors = tenyr_soc_i.tb_tenyr_assertions_i.fail_count;
        $display("Errors: %0d check, %0d assertion", errors, assert_errors);
        if (errors == 0 && assert_errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        #(runs * run_cycles * clk_period);
        $display("Watchdog expired: the program did not halt twice within %0d cycles",
                 runs * run_cycles);
        $display("TEST FAILED");
        $finish;
    end

endmodule

//--- tb_tenyr_assertions.sv
`timescale 1ns/1ps

module tb_tenyr_assertions (
    input logic        clk,
    input logic        arst_n,
    input logic        halt,
    input logic [15:0] display,
    input logic [7:0]  led
);

    int fail_count = 0;

    // Outputs are clear during reset and on the first edge after it
    reset_clears_outputs: assert property (
        @(posedge clk) (!arst_n || $rose(arst_n)) |-> (!halt && display == 16'd0 && led == 8'd0)
    ) else begin
        fail_count++;
        $error("halt, display or led is not clear around reset");
    end

    halt_is_sticky: assert property (
        @(posedge clk) disable iff (!arst_n) halt |=> halt
    ) else begin
        fail_count++;
        $error("halt fell without a reset");
    end

    outputs_frozen_on_halt: assert property (
        @(posedge clk) disable iff (!arst_n) halt |=> ($stable(display) && $stable(led))
    ) else begin
        fail_count++;
        $error("display or led changed while the core was halted");
    end

endmodule

bind tenyr_soc tb_tenyr_assertions tb_tenyr_assertions_i (
    .clk(clk), .arst_n(arst_n), .halt(halt), .display(display), .led(led)
);

//--- tenyr_pkg.sv
package tenyr_pkg;

    localparam int word_w = 32;
    localparam int addr_w = 11;

    localparam int ram_words = 1024;
    localparam int display_addr = 1024;
    localparam int led_addr = 1025;

    localparam int reg_count = 16; // Register 0 is hardwired to zero

    typedef enum logic [3:0] {
        ADD   = 4'h0,
        SUB   = 4'h1,
        AND   = 4'h2,
        OR    = 4'h3,
        XOR   = 4'h4,
        SHL   = 4'h5,
        LT    = 4'h6,
        LOAD  = 4'h7,
        STORE = 4'h8,
        BNZ   = 4'h9,
        HALT  = 4'hA,
        NOP   = 4'hF  // Every undefined code decodes to this
    } opcode_t;

    typedef enum logic [1:0] {
        FETCH     = 2'd0,
        EXEC      = 2'd1,
        LOAD_WAIT = 2'd2
    } core_state_t;

endpackage

//--- tenyr_soc.sv
`timescale 1ns/1ps

module tenyr_soc (
    input  logic        clk,
    input  logic        arst_n,
    output logic        halt,
    output logic [15:0] display,
    output logic [7:0]  led
);

    logic [tenyr_pkg::addr_w-1:0] i_addr;
    logic [tenyr_pkg::word_w-1:0] i_data;
    logic [tenyr_pkg::addr_w-1:0] d_addr;
    logic [tenyr_pkg::word_w-1:0] d_wdata;
    logic                         d_we;
    logic [tenyr_pkg::word_w-1:0] d_rdata;
    logic                         ram_we;
    logic [tenyr_pkg::word_w-1:0] ram_rdata;

    core core_i (
        .clk(clk), .arst_n(arst_n),
        .i_addr(i_addr), .i_data(i_data),
        .d_addr(d_addr), .d_wdata(d_wdata), .d_we(d_we), .d_rdata(d_rdata),
        .halt(halt)
    );

    // Instruction fetch on one port, loads and stores on the other
    block_mem block_mem_i (
        .clk(clk),
        .i_addr(i_addr), .i_data(i_data),
        .ram_addr(d_addr), .ram_we(ram_we), .ram_wdata(d_wdata),
        .ram_rdata(ram_rdata)
    );

    data_bus_map data_bus_map_i (
        .clk(clk), .arst_n(arst_n),
        .d_addr(d_addr), .d_wdata(d_wdata), .d_we(d_we), .d_rdata(d_rdata),
        .ram_we(ram_we), .ram_rdata(ram_rdata),
        .display(display), .led(led)
    );

endmodule
